// File: sim.f
common/mem_pkg.sv
rtl/addr_translate.sv
line_buffer/line_buffer.sv
rtl/uncached_bridge.sv
rtl/mem_arbiter.sv
rtl/mem_subsys_top.sv
sim/mem_model.sv
sim/mem_subsys_tb.sv

// File: run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module mem_subsys_tb -o mem_subsys_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/mem_subsys_sim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

// File: sim/mem_subsys_tb.sv
// tests stay in physical 0x000-0x3ff; uncached writes avoid the lines that cached accesses touch
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_tb import mem_pkg::*;;

    logic              aclk;
    logic              arst_n;
    logic              req;
    logic              wr;
    logic [1:0]        size;
    logic [31:0]       addr;
    logic [31:0]       wdata;
    logic              addr_ok;
    logic              data_ok;
    logic [31:0]       rdata;
    logic              mem_req;
    logic              mem_wr;
    logic              mem_burst;
    logic [31:0]       mem_addr;
    logic [31:0]       mem_wdata;
    logic [3:0]        mem_wstrb;
    logic              mem_ready;
    logic              mem_rvalid;
    logic [31:0]       mem_rdata;
    logic              mem_rlast;
    logic              mem_bvalid;

    logic [31:0] shadow [256];
    logic [32:0] exp_q [$];
    logic [32:0] exp_e;
    int          issued;
    int          resp_cnt;
    int          cycles;
    int          n0;
    logic [31:0] rnd;
    logic [31:0] pa;
    logic [31:0] base;
    logic [1:0]  sz;
    logic [1:0]  off;

    mem_subsys_top mem_subsys_top_inst (.*);

    mem_model mem_model_inst (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return 32'h1357_9bdf ^ (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
    endfunction

    // an access covers 2**size bytes starting at its byte offset
    function automatic logic [3:0] lane_mask(input logic [1:0] sz_i, input logic [1:0] off_i);
        int         nbytes;
        logic [3:0] m;
        nbytes = 1 << sz_i;
        for (int b = 0; b < 4; b++) begin
            m[b] = b >= int'(off_i) && b < int'(off_i) + nbytes;
        end
        return m;
    endfunction

    // shadow word after all earlier writes
    function automatic logic [31:0] expected_read(input logic [31:0] pa_i);
        return shadow[pa_i[9:2]];
    endfunction

    task automatic access(input logic w, input logic [1:0] sz_i, input logic [31:0] va,
                          input logic [31:0] wd);
        logic [31:0] p;
        logic [3:0]  m;
        p = {3'b000, va[28:0]};
        m = lane_mask(sz_i, va[1:0]);
        if (w) begin
            exp_q.push_back({1'b0, 32'h0});
            for (int b = 0; b < 4; b++) begin
                if (m[b]) begin
                    shadow[p[9:2]][8*b +: 8] = wd[8*b +: 8];
                end
            end
        end else begin
            exp_q.push_back({1'b1, expected_read(p)});
        end
        issued++;
        @(negedge aclk);
        req   = 1'b1;
        wr    = w;
        size  = sz_i;
        addr  = va;
        wdata = wd;
        #1;
        while (!addr_ok) begin
            @(negedge aclk);
            #1;
        end
        @(negedge aclk);
        req = 1'b0;
        while (resp_cnt != issued) begin
            @(posedge aclk);
        end
    endtask

    // every data_ok pops one expected entry
    always @(negedge aclk) begin
        if (arst_n && data_ok) begin
            assert (exp_q.size() > 0) else abort_run("data_ok with no request outstanding");
            exp_e = exp_q.pop_front();
            if (exp_e[32]) begin
                assert (rdata == exp_e[31:0]) else abort_run($sformatf(
                    "CHECK FAILED rdata: got %h expected %h", rdata, exp_e[31:0]));
            end
            resp_cnt++;
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > 200 * (issued + 1)) begin
            abort_run($sformatf("timeout: no response after %0d cycles", cycles));
        end
    end

    initial begin
        arst_n   = 1'b0;
        req      = 1'b0;
        wr       = 1'b0;
        size     = SIZE_WORD;
        addr     = '0;
        wdata    = '0;
        issued   = 0;
        resp_cnt = 0;
        cycles   = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = fill_word(32'(i) << 2);
        end
        repeat (2) @(negedge aclk);
        arst_n = 1'b1;

        // idle after reset
        repeat (5) begin
            @(negedge aclk);
            assert (addr_ok === 1'b1) else abort_run($sformatf(
                "CHECK FAILED addr_ok: got %h expected 1", addr_ok));
            assert (data_ok === 1'b0 && mem_req === 1'b0) else abort_run($sformatf(
                "CHECK FAILED data_ok/mem_req: got %h/%h expected 0/0", data_ok, mem_req));
        end

        // uncached write and read back
        access(1'b1, SIZE_WORD, 32'hA000_0100, 32'hcafe_f00d);
        access(1'b0, SIZE_WORD, 32'hA000_0100, 32'h0);
        assert (mem_model_inst.last_addr == 32'h0000_0100) else abort_run($sformatf(
            "CHECK FAILED mem_addr: got %h expected 00000100", mem_model_inst.last_addr));
        assert (!mem_model_inst.last_burst) else abort_run(
            "CHECK FAILED mem_burst: got 1 expected 0");

        // one burst refill serves the whole line
        n0 = mem_model_inst.req_count;
        access(1'b0, SIZE_WORD, 32'h8000_0024, 32'h0);
        assert (mem_model_inst.req_count == n0 + 1 && mem_model_inst.last_burst
                && mem_model_inst.last_addr == 32'h20) else abort_run($sformatf(
            "CHECK FAILED mem_addr: got %h expected 00000020 as one burst",
            mem_model_inst.last_addr));
        access(1'b0, SIZE_WORD, 32'h8000_0020, 32'h0);
        access(1'b0, SIZE_HALF, 32'h8000_0028, 32'h0);
        access(1'b0, SIZE_BYTE, 32'h8000_002f, 32'h0);
        assert (mem_model_inst.req_count == n0 + 1) else abort_run($sformatf(
            "CHECK FAILED mem_req count: got %h expected %h", mem_model_inst.req_count, n0 + 1));

        // sub-word writes at every offset, line buffered
        access(1'b0, SIZE_WORD, 32'h8000_0050, 32'h0);
        for (int o = 0; o < 4; o++) begin
            access(1'b1, SIZE_BYTE, 32'h8000_0054 + 32'(o), $urandom);
            access(1'b0, SIZE_WORD, 32'h8000_0054, 32'h0);
            access(1'b0, SIZE_WORD, 32'hA000_0054, 32'h0);
        end
        for (int o = 0; o < 4; o += 2) begin
            access(1'b1, SIZE_HALF, 32'h8000_0058 + 32'(o), $urandom);
            access(1'b0, SIZE_WORD, 32'h8000_0058, 32'h0);
            access(1'b0, SIZE_WORD, 32'hA000_0058, 32'h0);
        end

        // write hit then read on both paths
        access(1'b0, SIZE_WORD, 32'h8000_0060, 32'h0);
        access(1'b1, SIZE_WORD, 32'h8000_0064, 32'h0bad_beef);
        access(1'b0, SIZE_WORD, 32'h8000_0064, 32'h0);
        access(1'b0, SIZE_WORD, 32'hA000_0064, 32'h0);

        // random mix
        repeat (400) begin
            rnd = $urandom;
            sz  = (rnd[2:1] == 2'd3) ? SIZE_WORD : rnd[2:1];
            off = (sz == SIZE_BYTE) ? rnd[5:4] : (sz == SIZE_HALF) ? {rnd[4], 1'b0} : 2'b00;
            if (rnd[3] && (rnd[0] || rnd[10])) begin
                base = 32'h200 + {25'd0, rnd[8], 6'd0};
            end else begin
                base = {24'd0, rnd[9:8], 6'd0};
            end
            pa = base + {28'd0, rnd[7:6], off};
            access(rnd[0], sz, (rnd[3] ? 32'hA000_0000 : 32'h8000_0000) | pa, $urandom);
        end

        // idle cycles let a stray data_ok reach the compare process
        repeat (10) @(posedge aclk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/mem_model.sv
// word memory of 256 words at physical 0x000-0x3ff; addresses above wrap; drives on the falling edge
`timescale 1ns/1ns
`default_nettype none

module mem_model import mem_pkg::*; (
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              mem_req,
    input  logic              mem_wr,
    input  logic              mem_burst,
    input  logic [WORD_W-1:0] mem_addr,
    input  logic [WORD_W-1:0] mem_wdata,
    input  logic [3:0]        mem_wstrb,
    output logic              mem_ready,
    output logic              mem_rvalid,
    output logic [WORD_W-1:0] mem_rdata,
    output logic              mem_rlast,
    output logic              mem_bvalid
);

    localparam int DEPTH = 256;

    logic [31:0] mem [DEPTH];
    logic        busy;
    logic        wr_q;
    logic [7:0]  idx;
    logic [3:0]  strb_q;
    logic [31:0] wdata_q;
    logic [31:0] rnd;
    int          beats_left;
    int          wait_cnt;

    // observed by the testbench
    int          req_count;
    logic [31:0] last_addr;
    logic        last_burst;

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return 32'h1357_9bdf ^ (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
    endfunction

    initial begin
        void'($urandom(32'h2fb25ee2));
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = fill_word(32'(i) << 2);
        end
        mem_ready  = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        mem_rlast  = 1'b0;
        mem_bvalid = 1'b0;
        busy       = 1'b0;
        req_count  = 0;
        last_addr  = '0;
        last_burst = 1'b0;
        forever begin
            @(negedge aclk);
            mem_ready  = 1'b0;
            mem_rvalid = 1'b0;
            mem_rlast  = 1'b0;
            mem_bvalid = 1'b0;
            rnd        = $urandom;
            if (!arst_n) begin
                busy = 1'b0;
            end else if (!busy) begin
                // random stall on the request
                if (mem_req && rnd[1:0] != 2'b00) begin
                    mem_ready  = 1'b1;
                    busy       = 1'b1;
                    wr_q       = mem_wr;
                    idx        = mem_addr[9:2];
                    strb_q     = mem_wstrb;
                    wdata_q    = mem_wdata;
                    beats_left = mem_burst ? LINE_WORDS : 1;
                    wait_cnt   = int'(rnd[4:2]);
                    req_count++;
                    last_addr  = mem_addr;
                    last_burst = mem_burst;
                end
            end else if (wait_cnt > 0) begin
                wait_cnt--;
            end else if (wr_q) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb_q[b]) begin
                        mem[idx][8*b +: 8] = wdata_q[8*b +: 8];
                    end
                end
                mem_bvalid = 1'b1;
                busy       = 1'b0;
            end else if (rnd[7:5] != 3'b000) begin
                mem_rvalid = 1'b1;
                mem_rdata  = mem[idx];
                beats_left--;
                mem_rlast  = beats_left == 0;
                idx        = idx + 8'd1;
                if (beats_left == 0) begin
                    busy = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_subsys_top.sv
// cpu side allows one outstanding request; memory side must return beats in line order
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top import mem_pkg::*; (
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              req,
    input  logic              wr,
    input  logic [1:0]        size,
    input  logic [WORD_W-1:0] addr,
    input  logic [WORD_W-1:0] wdata,
    output logic              addr_ok,
    output logic              data_ok,
    output logic [WORD_W-1:0] rdata,
    output logic              mem_req,
    output logic              mem_wr,
    output logic              mem_burst,
    output logic [WORD_W-1:0] mem_addr,
    output logic [WORD_W-1:0] mem_wdata,
    output logic [3:0]        mem_wstrb,
    input  logic              mem_ready,
    input  logic              mem_rvalid,
    input  logic [WORD_W-1:0] mem_rdata,
    input  logic              mem_rlast,
    input  logic              mem_bvalid
);

    logic              c_req, c_wr, c_addr_ok, c_data_ok;
    logic [1:0]        c_size;
    logic [WORD_W-1:0] c_addr, c_wdata, c_rdata;
    logic              u_req, u_wr, u_addr_ok, u_data_ok;
    logic [1:0]        u_size;
    logic [WORD_W-1:0] u_addr, u_wdata, u_rdata;

    logic              lb_mreq, lb_mwr, lb_mburst, lb_mready, lb_rvalid, lb_rlast, lb_bvalid;
    logic [WORD_W-1:0] lb_maddr, lb_mwdata, lb_rdata;
    logic [3:0]        lb_mwstrb;
    logic              ub_mreq, ub_mwr, ub_mburst, ub_mready, ub_rvalid, ub_rlast, ub_bvalid;
    logic [WORD_W-1:0] ub_maddr, ub_mwdata, ub_rdata;
    logic [3:0]        ub_mwstrb;

    addr_translate addr_translate_inst (.*);

    line_buffer line_buffer_inst (.*);

    uncached_bridge uncached_bridge_inst (.*);

    // shared bus, line buffer first
    mem_arbiter mem_arbiter_inst (.*);

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
// two masters, fixed priority to the line buffer; one transaction on the bus at a time
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter import mem_pkg::*; (
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              lb_mreq,
    input  logic              lb_mwr,
    input  logic              lb_mburst,
    input  logic [WORD_W-1:0] lb_maddr,
    input  logic [WORD_W-1:0] lb_mwdata,
    input  logic [3:0]        lb_mwstrb,
    output logic              lb_mready,
    output logic              lb_rvalid,
    output logic [WORD_W-1:0] lb_rdata,
    output logic              lb_rlast,
    output logic              lb_bvalid,
    input  logic              ub_mreq,
    input  logic              ub_mwr,
    input  logic              ub_mburst,
    input  logic [WORD_W-1:0] ub_maddr,
    input  logic [WORD_W-1:0] ub_mwdata,
    input  logic [3:0]        ub_mwstrb,
    output logic              ub_mready,
    output logic              ub_rvalid,
    output logic [WORD_W-1:0] ub_rdata,
    output logic              ub_rlast,
    output logic              ub_bvalid,
    output logic              mem_req,
    output logic              mem_wr,
    output logic              mem_burst,
    output logic [WORD_W-1:0] mem_addr,
    output logic [WORD_W-1:0] mem_wdata,
    output logic [3:0]        mem_wstrb,
    input  logic              mem_ready,
    input  logic              mem_rvalid,
    input  logic [WORD_W-1:0] mem_rdata,
    input  logic              mem_rlast,
    input  logic              mem_bvalid
);

    logic busy;
    logic owner_ub;
    logic sel_ub;
    logic done;

    // owner locks as soon as a request shows, so it holds steady under stalls
    assign sel_ub = busy ? owner_ub : !lb_mreq;
    assign done   = (mem_rvalid && mem_rlast) || mem_bvalid;

    assign mem_req   = sel_ub ? ub_mreq : lb_mreq;
    assign mem_wr    = sel_ub ? ub_mwr : lb_mwr;
    assign mem_burst = sel_ub ? ub_mburst : lb_mburst;
    assign mem_addr  = sel_ub ? ub_maddr : lb_maddr;
    assign mem_wdata = sel_ub ? ub_mwdata : lb_mwdata;
    assign mem_wstrb = sel_ub ? ub_mwstrb : lb_mwstrb;

    assign lb_mready = mem_ready && !sel_ub;
    assign ub_mready = mem_ready && sel_ub;

    assign lb_rvalid = busy && !owner_ub && mem_rvalid;
    assign lb_rlast  = mem_rlast;
    assign lb_rdata  = mem_rdata;
    assign lb_bvalid = busy && !owner_ub && mem_bvalid;
    assign ub_rvalid = busy && owner_ub && mem_rvalid;
    assign ub_rlast  = mem_rlast;
    assign ub_rdata  = mem_rdata;
    assign ub_bvalid = busy && owner_ub && mem_bvalid;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            owner_ub <= 1'b0;
        end else if (!busy && mem_req) begin
            busy     <= 1'b1;
            owner_ub <= sel_ub;
        end else if (busy && done) begin
            busy <= 1'b0;
        end
    end

    // a stalled request keeps its master and its address
    assert property (@(posedge aclk) disable iff (!arst_n)
        mem_req && !mem_ready |=> mem_req && $stable(mem_addr));

endmodule

`default_nettype wire

// File: rtl/uncached_bridge.sv
// one word per access, never bursts; read data is held until the next request
`timescale 1ns/1ns
`default_nettype none

module uncached_bridge import mem_pkg::*; (
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              u_req,
    input  logic              u_wr,
    input  logic [1:0]        u_size,
    input  logic [WORD_W-1:0] u_addr,
    input  logic [WORD_W-1:0] u_wdata,
    output logic              u_addr_ok,
    output logic              u_data_ok,
    output logic [WORD_W-1:0] u_rdata,
    output logic              ub_mreq,
    output logic              ub_mwr,
    output logic              ub_mburst,
    output logic [WORD_W-1:0] ub_maddr,
    output logic [WORD_W-1:0] ub_mwdata,
    output logic [3:0]        ub_mwstrb,
    input  logic              ub_mready,
    input  logic              ub_rvalid,
    input  logic [WORD_W-1:0] ub_rdata,
    input  logic              ub_rlast,
    input  logic              ub_bvalid
);

    logic busy;
    logic resp;

    assign u_addr_ok = !busy && !resp;
    assign u_data_ok = resp;
    assign ub_mburst = 1'b0;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            resp    <= 1'b0;
            ub_mreq <= 1'b0;
        end else begin
            resp <= 1'b0;
            if (u_req && u_addr_ok) begin
                busy    <= 1'b1;
                ub_mreq <= 1'b1;
            end
            if (ub_mreq && ub_mready) begin
                ub_mreq <= 1'b0;
            end
            if (busy && (ub_rvalid || ub_bvalid)) begin
                busy <= 1'b0;
                resp <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (u_req && u_addr_ok) begin
            ub_mwr    <= u_wr;
            ub_maddr  <= u_addr;
            ub_mwdata <= u_wdata;
            ub_mwstrb <= strobe_of(u_size, u_addr[1:0]);
        end
        if (ub_rvalid) begin
            u_rdata <= ub_rdata;
        end
    end

    // the single beat this bridge gets back is also the last
    assert property (@(posedge aclk) disable iff (!arst_n) ub_rvalid |-> ub_rlast);

endmodule

`default_nettype wire

// File: line_buffer/line_buffer.sv
// single line, no write allocate; writes go straight to memory and update the line only on a hit
`timescale 1ns/1ns
`default_nettype none

module line_buffer import mem_pkg::*; (
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              c_req,
    input  logic              c_wr,
    input  logic [1:0]        c_size,
    input  logic [WORD_W-1:0] c_addr,
    input  logic [WORD_W-1:0] c_wdata,
    output logic              c_addr_ok,
    output logic              c_data_ok,
    output logic [WORD_W-1:0] c_rdata,
    output logic              lb_mreq,
    output logic              lb_mwr,
    output logic              lb_mburst,
    output logic [WORD_W-1:0] lb_maddr,
    output logic [WORD_W-1:0] lb_mwdata,
    output logic [3:0]        lb_mwstrb,
    input  logic              lb_mready,
    input  logic              lb_rvalid,
    input  logic [WORD_W-1:0] lb_rdata,
    input  logic              lb_rlast,
    input  logic              lb_bvalid
);

    logic [1:0]            state;
    logic                  valid;
    logic [TAG_W-1:0]      tag;
    logic [WORD_W-1:0]     line [LINE_WORDS];
    logic [LINE_IDX_W-1:0] beat;

    addr_u             in_a;
    addr_u             req_a;
    logic              wr_q;
    logic [WORD_W-1:0] wdata_q;
    logic [3:0]        strb_q;
    logic [WORD_W-1:0] rdata_q;
    logic [3:0]        in_strb;
    logic              hit;
    logic              accept;

    assign in_a    = c_addr;
    assign in_strb = strobe_of(c_size, in_a.line_view.byte_off);
    assign hit     = valid && tag == in_a.line_view.tag;
    assign accept  = c_req && c_addr_ok;

    assign c_addr_ok = state == LB_IDLE;
    assign c_data_ok = state == LB_RESP;
    assign c_rdata   = rdata_q;

    assign lb_mwr    = wr_q;
    assign lb_mburst = !wr_q;
    assign lb_mwdata = wdata_q;
    assign lb_mwstrb = strb_q;
    // refill starts at word 0 of the line
    assign lb_maddr  = wr_q ? req_a : {req_a.line_view.tag, {(LINE_IDX_W + 2){1'b0}}};

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= LB_IDLE;
            valid   <= 1'b0;
            lb_mreq <= 1'b0;
            beat    <= '0;
        end else begin
            if (lb_mreq && lb_mready) begin
                lb_mreq <= 1'b0;
            end
            case (state)
                LB_IDLE: begin
                    if (accept) begin
                        beat <= '0;
                        if (c_wr) begin
                            lb_mreq <= 1'b1;
                            state   <= LB_WWAIT;
                        end else if (hit) begin
                            state <= LB_RESP;
                        end else begin
                            valid   <= 1'b0;
                            lb_mreq <= 1'b1;
                            state   <= LB_REFILL;
                        end
                    end
                end
                LB_REFILL: begin
                    if (lb_rvalid) begin
                        beat <= beat + 1'b1;
                        if (lb_rlast) begin
                            valid <= 1'b1;
                            state <= LB_RESP;
                        end
                    end
                end
                LB_WWAIT: begin
                    if (lb_bvalid) begin
                        state <= LB_RESP;
                    end
                end
                default: begin
                    state <= LB_IDLE;
                end
            endcase
        end
    end

    // line words, tag and the latched request
    always_ff @(posedge aclk) begin
        if (accept) begin
            req_a   <= in_a;
            wr_q    <= c_wr;
            wdata_q <= c_wdata;
            strb_q  <= in_strb;
            rdata_q <= line[in_a.line_view.idx];
            if (c_wr && hit) begin
                for (int b = 0; b < 4; b++) begin
                    if (in_strb[b]) begin
                        line[in_a.line_view.idx][8*b +: 8] <= c_wdata[8*b +: 8];
                    end
                end
            end
        end
        if (state == LB_REFILL && lb_rvalid) begin
            line[beat] <= lb_rdata;
            tag        <= req_a.line_view.tag;
            if (beat == req_a.line_view.idx) begin
                rdata_q <= lb_rdata;
            end
        end
    end

    assert property (@(posedge aclk) disable iff (!arst_n) lb_rvalid |-> state == LB_REFILL);

    // burst length seen from the bus side must match the line
    assert property (@(posedge aclk) disable iff (!arst_n)
        lb_rvalid && lb_rlast |-> beat == LINE_IDX_W'(LINE_WORDS - 1));

endmodule

`default_nettype wire

// File: rtl/addr_translate.sv
// only kseg0/kseg1 are translated, no TLB; one request in flight across both paths
`timescale 1ns/1ns
`default_nettype none

module addr_translate import mem_pkg::*; (
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              req,
    input  logic              wr,
    input  logic [1:0]        size,
    input  logic [WORD_W-1:0] addr,
    input  logic [WORD_W-1:0] wdata,
    output logic              addr_ok,
    output logic              data_ok,
    output logic [WORD_W-1:0] rdata,
    output logic              c_req,
    output logic              c_wr,
    output logic [1:0]        c_size,
    output logic [WORD_W-1:0] c_addr,
    output logic [WORD_W-1:0] c_wdata,
    input  logic              c_addr_ok,
    input  logic              c_data_ok,
    input  logic [WORD_W-1:0] c_rdata,
    output logic              u_req,
    output logic              u_wr,
    output logic [1:0]        u_size,
    output logic [WORD_W-1:0] u_addr,
    output logic [WORD_W-1:0] u_wdata,
    input  logic              u_addr_ok,
    input  logic              u_data_ok,
    input  logic [WORD_W-1:0] u_rdata
);

    addr_u       va;
    logic [31:0] pa;
    logic        is_uc;
    logic        busy;
    logic        path_uc;

    assign va    = addr;
    assign is_uc = va.seg_view.seg == SEG_KSEG1;
    assign pa    = (va.seg_view.seg == SEG_KSEG0 || is_uc) ? {3'b000, va.seg_view.offset} : addr;

    assign c_req   = req && !busy && !is_uc;
    assign c_wr    = wr;
    assign c_size  = size;
    assign c_addr  = pa;
    assign c_wdata = wdata;

    assign u_req   = req && !busy && is_uc;
    assign u_wr    = wr;
    assign u_size  = size;
    assign u_addr  = pa;
    assign u_wdata = wdata;

    assign addr_ok = !busy && (is_uc ? u_addr_ok : c_addr_ok);
    assign data_ok = busy && (path_uc ? u_data_ok : c_data_ok);
    assign rdata   = path_uc ? u_rdata : c_rdata;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            path_uc <= 1'b0;
        end else if (req && addr_ok) begin
            busy    <= 1'b1;
            path_uc <= is_uc;
        end else if (data_ok) begin
            busy <= 1'b0;
        end
    end

    // neither path may answer a request this block never issued
    assert property (@(posedge aclk) disable iff (!arst_n) (c_data_ok || u_data_ok) |-> busy);

endmodule

`default_nettype wire

// File: common/mem_pkg.sv
// widths fixed at 32-bit words and a 4-word line; wdata is assumed byte-lane aligned by the CPU
`default_nettype none

package mem_pkg;

    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_IDX_W = $clog2(LINE_WORDS);
    localparam int TAG_W      = WORD_W - LINE_IDX_W - 2;

    // size field of the cpu port
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // unmapped segments
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    // line buffer states
    localparam logic [1:0] LB_IDLE   = 2'd0;
    localparam logic [1:0] LB_REFILL = 2'd1;
    localparam logic [1:0] LB_WWAIT  = 2'd2;
    localparam logic [1:0] LB_RESP   = 2'd3;

    typedef union packed {
        struct packed {
            logic [2:0]        seg;
            logic [WORD_W-4:0] offset;
        } seg_view;
        struct packed {
            logic [TAG_W-1:0]      tag;
            logic [LINE_IDX_W-1:0] idx;
            logic [1:0]            byte_off;
        } line_view;
    } addr_u;

    // byte lanes touched by an access
    function automatic logic [3:0] strobe_of(input logic [1:0] size, input logic [1:0] off);
        case (size)
            SIZE_BYTE: return 4'b0001 << off;
            SIZE_HALF: return off[1] ? 4'b1100 : 4'b0011;
            default:   return 4'b1111;
        endcase
    endfunction

endpackage

`default_nettype wire
